// File: rp_pkg.sv
// shared widths, bus regions and register map of the analog front end
// offsets are byte addresses inside one 1 MB region, word aligned
// region index sits in address bits 22..20, higher bits are ignored
package rp_pkg;

  // bus geometry
  localparam int RP_ADDR_W = 32;
  localparam int RP_DATA_W = 32;
  localparam int RP_SEL_W  = 4;   // one select per byte lane
  localparam int RP_OFFS_W = 20;  // offset inside a region

  // front end widths
  localparam int RP_ADC_W = 14;   // ADC and DAC sample
  localparam int RP_EXP_W = 8;    // expansion pins per row
  localparam int RP_LED_W = 8;
  localparam int RP_PWM_N = 4;    // slow PWM channels

  // 1 MB regions, picked by addr[22:20]
  typedef enum logic [2:0] {
    RP_REGION_HK      = 3'd0,
    RP_REGION_ANALOG  = 3'd1,
    RP_REGION_UNUSED2 = 3'd2,
    RP_REGION_UNUSED3 = 3'd3,
    RP_REGION_UNUSED4 = 3'd4,
    RP_REGION_UNUSED5 = 3'd5,
    RP_REGION_UNUSED6 = 3'd6,
    RP_REGION_UNUSED7 = 3'd7
  } rp_region_e;

  localparam logic [RP_DATA_W-1:0] RP_HK_ID = 32'h5250_0001;  // read-only ID word

  // housekeeping map
  localparam logic [RP_OFFS_W-1:0] RP_HK_ID_OFFS        = 20'h00000;
  localparam logic [RP_OFFS_W-1:0] RP_HK_LOOP_OFFS      = 20'h00004;
  localparam logic [RP_OFFS_W-1:0] RP_HK_EXP_P_DIR_OFFS = 20'h00010;
  localparam logic [RP_OFFS_W-1:0] RP_HK_EXP_N_DIR_OFFS = 20'h00014;
  localparam logic [RP_OFFS_W-1:0] RP_HK_EXP_P_OUT_OFFS = 20'h00018;
  localparam logic [RP_OFFS_W-1:0] RP_HK_EXP_N_OUT_OFFS = 20'h0001C;
  localparam logic [RP_OFFS_W-1:0] RP_HK_EXP_P_IN_OFFS  = 20'h00020;
  localparam logic [RP_OFFS_W-1:0] RP_HK_EXP_N_IN_OFFS  = 20'h00024;
  localparam logic [RP_OFFS_W-1:0] RP_HK_LED_OFFS       = 20'h00030;

  // analog map, duties are four words from RP_AN_PWM_OFFS on
  localparam logic [RP_OFFS_W-1:0] RP_AN_DAC_A_OFFS = 20'h00000;
  localparam logic [RP_OFFS_W-1:0] RP_AN_DAC_B_OFFS = 20'h00004;
  localparam logic [RP_OFFS_W-1:0] RP_AN_ADC_A_OFFS = 20'h00008;
  localparam logic [RP_OFFS_W-1:0] RP_AN_ADC_B_OFFS = 20'h0000C;
  localparam logic [RP_OFFS_W-1:0] RP_AN_PWM_OFFS   = 20'h00020;

endpackage

// File: rp_wb_if.sv
// Wishbone classic, one region, no error line
// adr carries only the region offset, the decoder strips the region bits
`timescale 1ns/1ps

interface rp_wb_if import rp_pkg::*; ();

  logic                 cyc;
  logic                 stb;    // gated per region by the decoder
  logic                 we;
  logic [RP_OFFS_W-1:0] adr;
  logic [RP_DATA_W-1:0] dat_w;
  logic [RP_SEL_W-1:0]  sel;
  logic [RP_DATA_W-1:0] dat_r;  // valid while ack
  logic                 ack;    // single cycle pulse

  modport master (
    output cyc, stb, we, adr, dat_w, sel,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack
  );

endinterface

// File: rp_pwm.sv
// slow PWM, period of 2**PWM_CNT_W adc_clk cycles
// duty counts high cycles per period, the all-ones code never reaches 100 %
`timescale 1ns/1ps

module rp_pwm #(
  parameter int PWM_CNT_W = 8
) (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  logic [PWM_CNT_W-1:0] duty_i,
  output logic                 pwm_o
);

  logic [PWM_CNT_W-1:0] cnt;  // wraps, no terminal count

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      cnt <= '0;
    else
      cnt <= cnt + 1'b1;
  end

  // high for counts 0 .. duty-1
  assign pwm_o = (cnt < duty_i);

  a_zero_duty_low: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (duty_i == '0) |-> !pwm_o);

endmodule

// File: rp_bus_decoder.sv
// splits the bus into eight 1 MB regions by addr[22:20]
// regions 2..7 are answered here with zero data, writes to them are dropped
// every region acks one cycle after cyc & stb, so no error path exists
`timescale 1ns/1ps

module rp_bus_decoder import rp_pkg::*; (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [RP_ADDR_W-1:0] wb_adr_i,
  input  logic [RP_DATA_W-1:0] wb_dat_i,
  input  logic [RP_SEL_W-1:0]  wb_sel_i,
  output logic [RP_DATA_W-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  rp_wb_if.master              hk_bus,
  rp_wb_if.master              an_bus
);

  rp_region_e region;
  logic       unused_sel;
  logic       unused_ack;  // local answer for empty regions

  assign region     = rp_region_e'(wb_adr_i[22:20]);
  assign unused_sel = (region != RP_REGION_HK) && (region != RP_REGION_ANALOG);

  // shared request lines, only stb is steered
  assign hk_bus.cyc   = wb_cyc_i;
  assign hk_bus.stb   = wb_stb_i && (region == RP_REGION_HK);
  assign hk_bus.we    = wb_we_i;
  assign hk_bus.adr   = wb_adr_i[RP_OFFS_W-1:0];
  assign hk_bus.dat_w = wb_dat_i;
  assign hk_bus.sel   = wb_sel_i;

  assign an_bus.cyc   = wb_cyc_i;
  assign an_bus.stb   = wb_stb_i && (region == RP_REGION_ANALOG);
  assign an_bus.we    = wb_we_i;
  assign an_bus.adr   = wb_adr_i[RP_OFFS_W-1:0];
  assign an_bus.dat_w = wb_dat_i;
  assign an_bus.sel   = wb_sel_i;

  // same one-pulse ack as the real slaves
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      unused_ack <= 1'b0;
    else
      unused_ack <= wb_cyc_i && wb_stb_i && unused_sel && !unused_ack;
  end

  ////////////////////////////////////////////////////////////////////////////
  // return path, merged by region
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    case (region)
      RP_REGION_HK:
      begin
        wb_dat_o = hk_bus.dat_r;
        wb_ack_o = hk_bus.ack;
      end
      RP_REGION_ANALOG:
      begin
        wb_dat_o = an_bus.dat_r;
        wb_ack_o = an_bus.ack;
      end
      default:
      begin
        wb_dat_o = '0;          // empty regions read zero
        wb_ack_o = unused_ack;
      end
    endcase
  end

  // no ack without a request in the cycle before, across all slaves
  a_ack_after_req: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i));

endmodule

// File: rp_housekeeping.sv
// housekeeping: ID, loop switch, expansion pins and LEDs
// registers are 8 bits wide in byte lane 0, the other lanes are ignored
// expansion inputs are asynchronous and pass two flops before readback
`timescale 1ns/1ps

module rp_housekeeping import rp_pkg::*; (
  input  logic                adc_clk,
  input  logic                rst_n_i,
  rp_wb_if.slave              bus,
  input  logic [RP_EXP_W-1:0] exp_p_i,
  input  logic [RP_EXP_W-1:0] exp_n_i,
  output logic [RP_EXP_W-1:0] exp_p_o,
  output logic [RP_EXP_W-1:0] exp_n_o,
  output logic [RP_EXP_W-1:0] exp_p_oe_o,  // 1 = drive the pin
  output logic [RP_EXP_W-1:0] exp_n_oe_o,
  output logic [RP_LED_W-1:0] led_o,
  output logic                digital_loop_o
);

  logic                 req;                     // new request, no ack yet
  logic [RP_EXP_W-1:0]  exp_p_meta, exp_p_sync;
  logic [RP_EXP_W-1:0]  exp_n_meta, exp_n_sync;
  logic [RP_DATA_W-1:0] rd_data;

  assign req = bus.cyc && bus.stb && !bus.ack;

  // two stage input sync
  always_ff @(posedge adc_clk)
  begin
    exp_p_meta <= exp_p_i;
    exp_p_sync <= exp_p_meta;
    exp_n_meta <= exp_n_i;
    exp_n_sync <= exp_n_meta;
  end

  ////////////////////////////////////////////////////////////////////////////
  // register writes, taken on the ack edge
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      exp_p_oe_o     <= '0;  // all pins start as inputs
      exp_n_oe_o     <= '0;
      exp_p_o        <= '0;
      exp_n_o        <= '0;
      led_o          <= '0;
    end
    else if (req && bus.we && bus.sel[0])
    begin
      case (bus.adr)
        RP_HK_LOOP_OFFS:      digital_loop_o <= bus.dat_w[0];
        RP_HK_EXP_P_DIR_OFFS: exp_p_oe_o     <= bus.dat_w[RP_EXP_W-1:0];
        RP_HK_EXP_N_DIR_OFFS: exp_n_oe_o     <= bus.dat_w[RP_EXP_W-1:0];
        RP_HK_EXP_P_OUT_OFFS: exp_p_o        <= bus.dat_w[RP_EXP_W-1:0];
        RP_HK_EXP_N_OUT_OFFS: exp_n_o        <= bus.dat_w[RP_EXP_W-1:0];
        RP_HK_LED_OFFS:       led_o          <= bus.dat_w[RP_LED_W-1:0];
        default: ;  // ID, inputs and holes are read only
      endcase
    end
  end

  // read mux, holes read zero
  always_comb
  begin
    case (bus.adr)
      RP_HK_ID_OFFS:        rd_data = RP_HK_ID;
      RP_HK_LOOP_OFFS:      rd_data = 32'(digital_loop_o);
      RP_HK_EXP_P_DIR_OFFS: rd_data = 32'(exp_p_oe_o);
      RP_HK_EXP_N_DIR_OFFS: rd_data = 32'(exp_n_oe_o);
      RP_HK_EXP_P_OUT_OFFS: rd_data = 32'(exp_p_o);
      RP_HK_EXP_N_OUT_OFFS: rd_data = 32'(exp_n_o);
      RP_HK_EXP_P_IN_OFFS:  rd_data = 32'(exp_p_sync);
      RP_HK_EXP_N_IN_OFFS:  rd_data = 32'(exp_n_sync);
      RP_HK_LED_OFFS:       rd_data = 32'(led_o);
      default:              rd_data = '0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      bus.ack <= 1'b0;
    else
      bus.ack <= req;  // one pulse, never back to back
  end

  always_ff @(posedge adc_clk)
  begin
    if (req)
      bus.dat_r <= rd_data;
  end

  a_ack_single: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    bus.ack |=> !bus.ack);

endmodule

// File: rp_analog_io.sv
// fast ADC capture and DAC output on adc_clk
// converter codes are unsigned with negative slope: keep the MSB,
// invert the rest, the same rule works both ways
`timescale 1ns/1ps

module rp_analog_io import rp_pkg::*; (
  input  logic                       adc_clk,
  input  logic                       rst_n_i,
  input  logic        [RP_ADC_W-1:0] adc_dat_a_i,
  input  logic        [RP_ADC_W-1:0] adc_dat_b_i,
  input  logic                       digital_loop_i,
  input  logic signed [RP_ADC_W-1:0] dac_lvl_a_i,
  input  logic signed [RP_ADC_W-1:0] dac_lvl_b_i,
  output logic signed [RP_ADC_W-1:0] adc_a_o,
  output logic signed [RP_ADC_W-1:0] adc_b_o,
  output logic        [RP_ADC_W-1:0] dac_dat_a_o,
  output logic        [RP_ADC_W-1:0] dac_dat_b_o
);

  logic [RP_ADC_W-1:0] adc_raw_a, adc_raw_b;  // IOB capture stage

  ////////////////////////////////////////////////////////////////////////////
  // ADC path
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    adc_raw_a <= adc_dat_a_i;
    adc_raw_b <= adc_dat_b_i;
  end

  // loop switch bypasses the converter with the DAC levels
  assign adc_a_o = digital_loop_i ? dac_lvl_a_i
                                  : {adc_raw_a[RP_ADC_W-1], ~adc_raw_a[RP_ADC_W-2:0]};
  assign adc_b_o = digital_loop_i ? dac_lvl_b_i
                                  : {adc_raw_b[RP_ADC_W-1], ~adc_raw_b[RP_ADC_W-2:0]};

  ////////////////////////////////////////////////////////////////////////////
  // DAC path, one register per channel
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      // code of a zero level
      dac_dat_a_o <= {1'b0, {(RP_ADC_W-1){1'b1}}};
      dac_dat_b_o <= {1'b0, {(RP_ADC_W-1){1'b1}}};
    end
    else
    begin
      dac_dat_a_o <= {dac_lvl_a_i[RP_ADC_W-1], ~dac_lvl_a_i[RP_ADC_W-2:0]};
      dac_dat_b_o <= {dac_lvl_b_i[RP_ADC_W-1], ~dac_lvl_b_i[RP_ADC_W-2:0]};
    end
  end

endmodule

// File: rp_analog_regs.sv
// analog registers: two DAC levels, ADC readback, four PWM duties
// writes honour the byte selects, ADC samples read back sign extended
// PWM_CNT_W must not exceed the bus width
`timescale 1ns/1ps

module rp_analog_regs import rp_pkg::*; #(
  parameter int PWM_CNT_W = 8
) (
  input  logic                                 adc_clk,
  input  logic                                 rst_n_i,
  rp_wb_if.slave                               bus,
  input  logic signed [RP_ADC_W-1:0]           adc_a_i,
  input  logic signed [RP_ADC_W-1:0]           adc_b_i,
  output logic signed [RP_ADC_W-1:0]           dac_lvl_a_o,
  output logic signed [RP_ADC_W-1:0]           dac_lvl_b_o,
  output logic [RP_PWM_N-1:0][PWM_CNT_W-1:0]   pwm_duty_o
);

  logic                 req;
  logic [RP_DATA_W-1:0] rd_data;

  assign req = bus.cyc && bus.stb && !bus.ack;

  // replace the selected byte lanes of a register word
  function automatic logic [RP_DATA_W-1:0] lane_merge(input logic [RP_DATA_W-1:0] old_w,
                                                      input logic [RP_DATA_W-1:0] new_w,
                                                      input logic [RP_SEL_W-1:0]  sel);
    logic [RP_DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < RP_SEL_W; b++)
      if (sel[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // writes on the ack edge
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_lvl_a_o <= '0;
      dac_lvl_b_o <= '0;
      pwm_duty_o  <= '0;  // PWM outputs idle low
    end
    else if (req && bus.we)
    begin
      if (bus.adr == RP_AN_DAC_A_OFFS)
        dac_lvl_a_o <= RP_ADC_W'(lane_merge(32'(dac_lvl_a_o), bus.dat_w, bus.sel));
      if (bus.adr == RP_AN_DAC_B_OFFS)
        dac_lvl_b_o <= RP_ADC_W'(lane_merge(32'(dac_lvl_b_o), bus.dat_w, bus.sel));
      for (int i = 0; i < RP_PWM_N; i++)
        if (bus.adr == RP_AN_PWM_OFFS + RP_OFFS_W'(4 * i))
          pwm_duty_o[i] <= PWM_CNT_W'(lane_merge(32'(pwm_duty_o[i]), bus.dat_w, bus.sel));
    end
  end

  // read mux, signed casts sign extend
  always_comb
  begin
    rd_data = '0;
    case (bus.adr)
      RP_AN_DAC_A_OFFS: rd_data = 32'(dac_lvl_a_o);
      RP_AN_DAC_B_OFFS: rd_data = 32'(dac_lvl_b_o);
      RP_AN_ADC_A_OFFS: rd_data = 32'(adc_a_i);
      RP_AN_ADC_B_OFFS: rd_data = 32'(adc_b_i);
      default: ;
    endcase
    for (int i = 0; i < RP_PWM_N; i++)
      if (bus.adr == RP_AN_PWM_OFFS + RP_OFFS_W'(4 * i))
        rd_data = 32'(pwm_duty_o[i]);
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      bus.ack <= 1'b0;
    else
      bus.ack <= req;
  end

  always_ff @(posedge adc_clk)
  begin
    if (req)
      bus.dat_r <= rd_data;  // held through the ack cycle
  end

  a_ack_single: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    bus.ack |=> !bus.ack);

endmodule

// File: rp_top.sv
// analog front end top level, single adc_clk domain
// region 0 housekeeping, region 1 analog registers, regions 2..7 empty
// expansion pins are split into in, out and enable, buffers sit outside
`timescale 1ns/1ps

module rp_top import rp_pkg::*; #(
  parameter int PWM_CNT_W = 8   // PWM counter and duty width
) (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  // bus from the outside master
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [RP_ADDR_W-1:0] wb_adr_i,
  input  logic [RP_DATA_W-1:0] wb_dat_i,
  input  logic [RP_SEL_W-1:0]  wb_sel_i,
  output logic [RP_DATA_W-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  // converters
  input  logic [RP_ADC_W-1:0]  adc_dat_a_i,
  input  logic [RP_ADC_W-1:0]  adc_dat_b_i,
  output logic [RP_ADC_W-1:0]  dac_dat_a_o,
  output logic [RP_ADC_W-1:0]  dac_dat_b_o,
  output logic [RP_PWM_N-1:0]  dac_pwm_o,
  // expansion connector and LEDs
  input  logic [RP_EXP_W-1:0]  exp_p_i,
  input  logic [RP_EXP_W-1:0]  exp_n_i,
  output logic [RP_EXP_W-1:0]  exp_p_o,
  output logic [RP_EXP_W-1:0]  exp_n_o,
  output logic [RP_EXP_W-1:0]  exp_p_oe_o,
  output logic [RP_EXP_W-1:0]  exp_n_oe_o,
  output logic [RP_LED_W-1:0]  led_o
);

  logic                               digital_loop;
  logic signed [RP_ADC_W-1:0]         adc_a, adc_b;          // two's complement samples
  logic signed [RP_ADC_W-1:0]         dac_lvl_a, dac_lvl_b;
  logic [RP_PWM_N-1:0][PWM_CNT_W-1:0] pwm_duty;

  rp_wb_if hk_bus ();
  rp_wb_if an_bus ();

  rp_bus_decoder u_decoder (
    .adc_clk, .rst_n_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
    .wb_dat_o, .wb_ack_o,
    .hk_bus   (hk_bus.master),
    .an_bus   (an_bus.master)
  );

  rp_housekeeping u_hk (
    .adc_clk, .rst_n_i,
    .bus            (hk_bus.slave),
    .exp_p_i, .exp_n_i, .exp_p_o, .exp_n_o, .exp_p_oe_o, .exp_n_oe_o,
    .led_o,
    .digital_loop_o (digital_loop)
  );

  rp_analog_io u_analog_io (
    .adc_clk, .rst_n_i,
    .adc_dat_a_i, .adc_dat_b_i,
    .digital_loop_i (digital_loop),
    .dac_lvl_a_i    (dac_lvl_a),
    .dac_lvl_b_i    (dac_lvl_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b),
    .dac_dat_a_o, .dac_dat_b_o
  );

  rp_analog_regs #(.PWM_CNT_W(PWM_CNT_W)) u_analog_regs (
    .adc_clk, .rst_n_i,
    .bus         (an_bus.slave),
    .adc_a_i     (adc_a),
    .adc_b_i     (adc_b),
    .dac_lvl_a_o (dac_lvl_a),
    .dac_lvl_b_o (dac_lvl_b),
    .pwm_duty_o  (pwm_duty)
  );

  // one slow PWM per channel
  for (genvar i = 0; i < RP_PWM_N; i++)
  begin : g_pwm
    rp_pwm #(.PWM_CNT_W(PWM_CNT_W)) u_pwm (
      .adc_clk, .rst_n_i,
      .duty_i (pwm_duty[i]),
      .pwm_o  (dac_pwm_o[i])
    );
  end

endmodule

// File: tb_rp_top.sv
// directed testbench for the analog front end top level
// inputs change 2 ns after the rising edge, outputs are sampled there too
// stops at the first mismatch or bus timeout
`timescale 1ns/1ps

module tb_rp_top import rp_pkg::*; ();

  localparam int PWM_CNT     = 8;   // counter width handed to the DUT
  localparam int ACK_TIMEOUT = 16;  // cycles before a transfer is given up

  logic                 adc_clk, rst_n_i;
  logic                 wb_cyc_i, wb_stb_i, wb_we_i;
  logic [RP_ADDR_W-1:0] wb_adr_i;
  logic [RP_DATA_W-1:0] wb_dat_i, wb_dat_o;
  logic [RP_SEL_W-1:0]  wb_sel_i;
  logic                 wb_ack_o;
  logic [RP_ADC_W-1:0]  adc_dat_a_i, adc_dat_b_i, dac_dat_a_o, dac_dat_b_o;
  logic [RP_PWM_N-1:0]  dac_pwm_o;
  logic [RP_EXP_W-1:0]  exp_p_i, exp_n_i, exp_p_o, exp_n_o, exp_p_oe_o, exp_n_oe_o;
  logic [RP_LED_W-1:0]  led_o;

  integer               seed = 32'h5c6dfb03;
  logic [RP_LED_W-1:0]  led_exp;    // model of the LED register
  logic [RP_ADC_W-1:0]  dac_a_exp;  // model of the DAC A level

  rp_top #(.PWM_CNT_W(PWM_CNT)) UUT (
    .adc_clk, .rst_n_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
    .wb_dat_o, .wb_ack_o,
    .adc_dat_a_i, .adc_dat_b_i, .dac_dat_a_o, .dac_dat_b_o, .dac_pwm_o,
    .exp_p_i, .exp_n_i, .exp_p_o, .exp_n_o, .exp_p_oe_o, .exp_n_oe_o,
    .led_o
  );

  initial adc_clk = 1'b0;
  always #20 adc_clk = ~adc_clk;  // 40 ns period

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [RP_ADDR_W-1:0] reg_addr(input rp_region_e region,
                                                    input logic [RP_OFFS_W-1:0] offs);
    return {{(RP_ADDR_W-23){1'b0}}, 3'(region), offs};  // region in bits 22..20
  endfunction

  // negative slope code <-> two's complement, MSB kept
  function automatic logic [RP_ADC_W-1:0] flip_code(input logic [RP_ADC_W-1:0] v);
    return v ^ {1'b0, {(RP_ADC_W-1){1'b1}}};
  endfunction

  function automatic logic [RP_DATA_W-1:0] sign_extend(input logic [RP_ADC_W-1:0] v);
    return {{(RP_DATA_W-RP_ADC_W){v[RP_ADC_W-1]}}, v};
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h",
               $time, name, actual, expected);
      $display("Errors found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // one classic cycle, called at 2 ns after an edge and returns the same way
  task automatic bus_cycle(input logic we, input logic [RP_ADDR_W-1:0] addr,
                           input logic [RP_DATA_W-1:0] wdata,
                           input logic [RP_SEL_W-1:0] sel,
                           output logic [RP_DATA_W-1:0] rdata);
    int waited;
    waited   = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = addr;
    wb_dat_i = wdata;
    wb_sel_i = sel;
    do
    begin
      @(posedge adc_clk);
      #2;
      waited++;
    end
    while (!wb_ack_o && waited < ACK_TIMEOUT);
    if (!wb_ack_o)
    begin
      $display("bus timeout, no ack within %0d cycles at address 0x%08h", ACK_TIMEOUT, addr);
      $display("Errors found");
      $fatal(1, "bus transfer timed out");
    end
    else
    begin
      rdata    = wb_dat_o;  // valid while ack is high
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      check_value("ack latency", waited, 1);  // ack one cycle after the request
      // one idle edge, the slave then sees the next request as new
      @(posedge adc_clk);
      #2;
    end
  endtask

  task automatic wb_write(input logic [RP_ADDR_W-1:0] addr, input logic [RP_DATA_W-1:0] data,
                          input logic [RP_SEL_W-1:0] sel = 4'hF);
    logic [RP_DATA_W-1:0] unused;
    bus_cycle(1'b1, addr, data, sel, unused);
  endtask

  task automatic wb_read(input logic [RP_ADDR_W-1:0] addr, output logic [RP_DATA_W-1:0] data);
    bus_cycle(1'b0, addr, '0, 4'hF, data);
  endtask

  // read and compare in one go
  task automatic read_check(input string name, input logic [RP_ADDR_W-1:0] addr,
                            input logic [RP_DATA_W-1:0] expected);
    logic [RP_DATA_W-1:0] data;
    wb_read(addr, data);
    check_value(name, data, expected);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic test_reset_id();
    check_value("led_o", led_o, 0);
    check_value("exp_p_oe_o", exp_p_oe_o, 0);  // all pins inputs
    check_value("exp_n_oe_o", exp_n_oe_o, 0);
    check_value("dac_pwm_o", dac_pwm_o, 0);
    check_value("dac_dat_a_o", dac_dat_a_o, flip_code('0));  // zero level
    check_value("dac_dat_b_o", dac_dat_b_o, flip_code('0));
    read_check("hk id", reg_addr(RP_REGION_HK, RP_HK_ID_OFFS), RP_HK_ID);
    read_check("hk loop", reg_addr(RP_REGION_HK, RP_HK_LOOP_OFFS), 0);
  endtask

  task automatic test_housekeeping();
    logic [RP_EXP_W-1:0] p_in, n_in;
    led_exp = 8'hA5;
    wb_write(reg_addr(RP_REGION_HK, RP_HK_LED_OFFS), 32'(led_exp));
    wb_write(reg_addr(RP_REGION_HK, RP_HK_EXP_P_DIR_OFFS), 32'h3C);
    wb_write(reg_addr(RP_REGION_HK, RP_HK_EXP_N_DIR_OFFS), 32'hC3);
    wb_write(reg_addr(RP_REGION_HK, RP_HK_EXP_P_OUT_OFFS), 32'h5A);
    wb_write(reg_addr(RP_REGION_HK, RP_HK_EXP_N_OUT_OFFS), 32'h96);
    check_value("led_o", led_o, led_exp);
    check_value("exp_p_oe_o", exp_p_oe_o, 8'h3C);
    check_value("exp_n_oe_o", exp_n_oe_o, 8'hC3);
    check_value("exp_p_o", exp_p_o, 8'h5A);
    check_value("exp_n_o", exp_n_o, 8'h96);
    read_check("hk led", reg_addr(RP_REGION_HK, RP_HK_LED_OFFS), 32'(led_exp));
    read_check("hk p dir", reg_addr(RP_REGION_HK, RP_HK_EXP_P_DIR_OFFS), 32'h3C);
    read_check("hk n dir", reg_addr(RP_REGION_HK, RP_HK_EXP_N_DIR_OFFS), 32'hC3);
    read_check("hk p out", reg_addr(RP_REGION_HK, RP_HK_EXP_P_OUT_OFFS), 32'h5A);
    read_check("hk n out", reg_addr(RP_REGION_HK, RP_HK_EXP_N_OUT_OFFS), 32'h96);
    // lane 0 not selected, LED byte stays
    wb_write(reg_addr(RP_REGION_HK, RP_HK_LED_OFFS), 32'hFF, 4'b1110);
    check_value("led_o", led_o, led_exp);
    // low lane only on a DAC level
    wb_write(reg_addr(RP_REGION_ANALOG, RP_AN_DAC_A_OFFS), 32'h1234);
    wb_write(reg_addr(RP_REGION_ANALOG, RP_AN_DAC_A_OFFS), 32'h3F56, 4'b0001);
    dac_a_exp = 14'h1256;
    read_check("dac a level", reg_addr(RP_REGION_ANALOG, RP_AN_DAC_A_OFFS), 32'h1256);
    // expansion inputs through the two sync flops
    p_in    = 8'($random(seed));
    n_in    = 8'($random(seed));
    exp_p_i = p_in;
    exp_n_i = n_in;
    repeat (2) @(posedge adc_clk);
    #2;
    read_check("hk p in", reg_addr(RP_REGION_HK, RP_HK_EXP_P_IN_OFFS), 32'(p_in));
    read_check("hk n in", reg_addr(RP_REGION_HK, RP_HK_EXP_N_IN_OFFS), 32'(n_in));
  endtask

  task automatic test_adc_conversion();
    logic [RP_ADC_W-1:0] raw_a, raw_b;
    for (int k = 0; k < 8; k++)
    begin
      raw_a       = 14'($random(seed));
      raw_b       = 14'($random(seed));
      adc_dat_a_i = raw_a;
      adc_dat_b_i = raw_b;
      @(posedge adc_clk);  // capture register
      #2;
      read_check("adc a", reg_addr(RP_REGION_ANALOG, RP_AN_ADC_A_OFFS),
                 sign_extend(flip_code(raw_a)));
      read_check("adc b", reg_addr(RP_REGION_ANALOG, RP_AN_ADC_B_OFFS),
                 sign_extend(flip_code(raw_b)));
    end
  endtask

  task automatic test_dac_loop();
    logic [RP_ADC_W-1:0] lvl_a, lvl_b;
    wb_write(reg_addr(RP_REGION_HK, RP_HK_LOOP_OFFS), 32'h1);  // loop on
    for (int k = 0; k < 6; k++)
    begin
      lvl_a = 14'($random(seed));
      lvl_b = 14'($random(seed));
      wb_write(reg_addr(RP_REGION_ANALOG, RP_AN_DAC_A_OFFS), 32'(lvl_a));
      wb_write(reg_addr(RP_REGION_ANALOG, RP_AN_DAC_B_OFFS), 32'(lvl_b));
      dac_a_exp = lvl_a;
      @(posedge adc_clk);  // output register
      #2;
      check_value("dac_dat_a_o", dac_dat_a_o, flip_code(lvl_a));
      check_value("dac_dat_b_o", dac_dat_b_o, flip_code(lvl_b));
      read_check("loop adc a", reg_addr(RP_REGION_ANALOG, RP_AN_ADC_A_OFFS), sign_extend(lvl_a));
      read_check("loop adc b", reg_addr(RP_REGION_ANALOG, RP_AN_ADC_B_OFFS), sign_extend(lvl_b));
    end
    wb_write(reg_addr(RP_REGION_HK, RP_HK_LOOP_OFFS), 32'h0);
  endtask

  task automatic test_pwm();
    logic [PWM_CNT-1:0] duty;
    int                 high;
    for (int ch = 0; ch < RP_PWM_N; ch++)
    begin
      for (int k = 0; k < 5; k++)
      begin
        case (k)
          0:       duty = '0;
          1:       duty = 1;
          2:       duty = 128;
          3:       duty = '1;  // all ones, one low cycle left
          default: duty = PWM_CNT'($random(seed));
        endcase
        wb_write(reg_addr(RP_REGION_ANALOG, RP_AN_PWM_OFFS + RP_OFFS_W'(4 * ch)), 32'(duty));
        high = 0;
        repeat (2 ** PWM_CNT)  // one full period, any phase
        begin
          @(posedge adc_clk);
          #2;
          if (dac_pwm_o[ch])
            high++;
        end
        check_value($sformatf("dac_pwm_o[%0d] high cycles", ch), high, 32'(duty));
      end
      wb_write(reg_addr(RP_REGION_ANALOG, RP_AN_PWM_OFFS + RP_OFFS_W'(4 * ch)), 32'h0);
    end
    check_value("dac_pwm_o", dac_pwm_o, 0);
  endtask

  task automatic test_unused_regions();
    for (int r = 2; r < 8; r++)
    begin
      read_check($sformatf("region %0d read", r), reg_addr(rp_region_e'(r), RP_HK_ID_OFFS), 0);
      wb_write(reg_addr(rp_region_e'(r), RP_HK_LED_OFFS), 32'h0F);  // same offset as LEDs
      wb_write(reg_addr(rp_region_e'(r), RP_AN_DAC_A_OFFS), 32'h0777);
    end
    check_value("led_o", led_o, led_exp);
    read_check("hk led", reg_addr(RP_REGION_HK, RP_HK_LED_OFFS), 32'(led_exp));
    read_check("dac a level", reg_addr(RP_REGION_ANALOG, RP_AN_DAC_A_OFFS), sign_extend(dac_a_exp));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    rst_n_i     = 1'b0;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    wb_we_i     = 1'b0;
    wb_adr_i    = '0;
    wb_dat_i    = '0;
    wb_sel_i    = '0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    exp_p_i     = '0;
    exp_n_i     = '0;
    repeat (2) @(posedge adc_clk);
    #2;
    rst_n_i = 1'b1;
    test_reset_id();
    test_housekeeping();
    test_adc_conversion();
    test_dac_loop();
    test_pwm();
    test_unused_regions();
    $display("No errors");
    $finish;
  end

endmodule

// File: rp.f
rp_pkg.sv
rp_wb_if.sv
rp_pwm.sv
rp_bus_decoder.sv
rp_housekeeping.sv
rp_analog_io.sv
rp_analog_regs.sv
rp_top.sv
tb_rp_top.sv

// File: Bender.yml
package:
  name: rp

sources:
  - rp_pkg.sv
  - rp_wb_if.sv
  - rp_pwm.sv
  - rp_bus_decoder.sv
  - rp_housekeeping.sv
  - rp_analog_io.sv
  - rp_analog_regs.sv
  - rp_top.sv
  - target: test
    files:
      - tb_rp_top.sv
